/* logic/cpuTypes.sv */
package cpuTypes;

	typedef logic [15:0] word_t;    // data or address word
	typedef logic [2:0]  regIdx_t;  // register index
	typedef logic [3:0]  flags_t;   // zero, negative, carry, overflow

	// bit positions inside flags_t
	parameter int flagZero     = 3;
	parameter int flagNegative = 2;
	parameter int flagCarry    = 1;
	parameter int flagOverflow = 0;

	// register ops sit on codes 0..6 so their low bits match aluOp_t
	typedef enum logic [3:0] {
		opAdd  = 4'h0, opSub  = 4'h1, opAnd  = 4'h2, opOr   = 4'h3,
		opXor  = 4'h4, opShl  = 4'h5, opShr  = 4'h6, opAddi = 4'h7,
		opLd   = 4'h8, opSt   = 4'h9, opBz   = 4'hA, opJal  = 4'hB,
		opRet  = 4'hC, opPush = 4'hD, opPop  = 4'hE, opHalt = 4'hF
	} opcode_t;

	typedef enum logic [2:0] {
		aluAdd, aluSub, aluAnd, aluOr, aluXor, aluShl, aluShr, aluPassB
	} aluOp_t;

	typedef enum logic [1:0] {pcPlus1, pcAluOut, pcLr, pcBus} pcSel_t;
	typedef enum logic [1:0] {op1Rd1, op1Pc, op1Sp} op1Sel_t;
	typedef enum logic [1:0] {op2Rd2, op2Imm, op2One} op2Sel_t;
	typedef enum logic [1:0] {busMem, busAluOut, busLr, busRd2} busSel_t;
	typedef enum logic [1:0] {addrPc, addrAluOut, addrSp} addrSel_t;

	// sIdle is where reset parks the FSM before the first fetch
	typedef enum logic [2:0] {
		sIdle, sFetch, sDecode, sExecute, sMemAddr, sMemRead, sWriteBack, sHalted
	} cpuState_t;

	typedef struct packed {
		logic  read;
		logic  write;
		word_t addr;
		word_t wdata;
	} memReq_t;

	typedef struct packed {
		aluOp_t   aluOp;
		pcSel_t   pcSel;
		op1Sel_t  op1Sel;
		op2Sel_t  op2Sel;
		busSel_t  busSel;
		addrSel_t addrSel;
		logic     immSel;   // imm9 rather than imm6
		logic     rdAsRs2;  // read port 2 addressed by rd
		logic     wdSel;    // reg write data from the bus
		logic     pcWe;
		logic     lrWe;
		logic     spWe;
		logic     irWe;
		logic     aluWe;
		logic     flagWe;
		logic     regWe;
		logic     memRead;
		logic     memWrite;
	} ctrl_t;

endpackage

/* logic/alu.sv */
module alu (
	input  cpuTypes::word_t  a,
	input  cpuTypes::word_t  b,
	input  cpuTypes::aluOp_t op,
	output cpuTypes::word_t  result,
	output cpuTypes::flags_t flags
);

	logic [16:0] wide;  // bit 16 holds carry or borrow
	logic        carry;
	logic        overflow;

	always_comb begin
		wide = '0;
		carry = 1'b0;
		overflow = 1'b0;
		case (op)
			cpuTypes::aluAdd: begin
				wide = {1'b0, a} + {1'b0, b};
				carry = wide[16];
				overflow = (a[15] == b[15]) && (wide[15] != a[15]);
			end
			cpuTypes::aluSub: begin
				wide = {1'b0, a} - {1'b0, b};
				carry = wide[16];  // set on borrow
				overflow = (a[15] != b[15]) && (wide[15] != a[15]);
			end
			cpuTypes::aluAnd: wide = {1'b0, a & b};
			cpuTypes::aluOr:  wide = {1'b0, a | b};
			cpuTypes::aluXor: wide = {1'b0, a ^ b};
			cpuTypes::aluShl: wide = {1'b0, a[14:0], 1'b0};  // single bit shifts
			cpuTypes::aluShr: wide = {2'b00, a[15:1]};
			default:          wide = {1'b0, b};  // passB
		endcase
	end

	assign result = wide[15:0];

	assign flags[cpuTypes::flagZero]     = (result == '0);
	assign flags[cpuTypes::flagNegative] = result[15];
	assign flags[cpuTypes::flagCarry]    = carry;
	assign flags[cpuTypes::flagOverflow] = overflow;

endmodule

/* logic/regBlock.sv */
module regBlock (
	input  logic              Clock,
	input  logic              rstN,
	input  cpuTypes::regIdx_t rs1,
	input  cpuTypes::regIdx_t rs2,
	input  cpuTypes::regIdx_t rw,
	input  logic              we,
	input  cpuTypes::word_t   wData,
	output cpuTypes::word_t   rd1,
	output cpuTypes::word_t   rd2
);

	cpuTypes::word_t regs [8];

	// r0 is cleared here and never written, so it always reads zero
	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (rw != '0)) begin
			regs[rw] <= wData;
		end
	end

	assign rd1 = regs[rs1];
	assign rd2 = regs[rs2];

endmodule

/* logic/datapath.sv */
module datapath #(
	parameter cpuTypes::word_t resetPc  = 16'h0000,
	parameter cpuTypes::word_t stackTop = 16'h00FF
) (
	input  logic               Clock,
	input  logic               rstN,
	input  cpuTypes::ctrl_t    ctrl,
	input  cpuTypes::word_t    memRData,
	output cpuTypes::memReq_t  memReq,
	output cpuTypes::opcode_t  opcode,
	output cpuTypes::flags_t   flags
);

	cpuTypes::word_t  pc, lr, sp, ir, aluOut;
	cpuTypes::word_t  pcIn, op1, op2, sysBus, regWData, immExt;
	cpuTypes::word_t  rd1, rd2, aluResult;
	cpuTypes::flags_t aluFlags;
	cpuTypes::regIdx_t rs2Idx;
	logic             instrArriving;  // previous cycle was an instruction fetch

	// the fetched word lands during decode, before IR holds it
	assign opcode = cpuTypes::opcode_t'(instrArriving ? memRData[15:12] : ir[15:12]);

	assign immExt = ctrl.immSel ? {{7{ir[8]}}, ir[8:0]}   // branch offset
	                            : {{10{ir[5]}}, ir[5:0]};

	assign rs2Idx = ctrl.rdAsRs2 ? ir[11:9] : ir[5:3];  // ST and PUSH source rd

	always_comb begin
		case (ctrl.op1Sel)
			cpuTypes::op1Pc: op1 = pc;
			cpuTypes::op1Sp: op1 = sp;
			default:         op1 = rd1;
		endcase
		case (ctrl.op2Sel)
			cpuTypes::op2Imm: op2 = immExt;
			cpuTypes::op2One: op2 = 16'd1;
			default:          op2 = rd2;
		endcase
	end

	// system bus mux
	always_comb begin
		case (ctrl.busSel)
			cpuTypes::busAluOut: sysBus = aluOut;
			cpuTypes::busLr:     sysBus = lr;
			cpuTypes::busRd2:    sysBus = rd2;
			default:             sysBus = memRData;
		endcase
	end

	always_comb begin
		case (ctrl.pcSel)
			cpuTypes::pcAluOut: pcIn = aluResult;  // target taken in the same cycle
			cpuTypes::pcLr:     pcIn = lr;
			cpuTypes::pcBus:    pcIn = sysBus;
			default:            pcIn = pc + 16'd1;
		endcase
	end

	assign regWData = ctrl.wdSel ? sysBus : aluOut;

	always_comb begin
		memReq.read  = ctrl.memRead;
		memReq.write = ctrl.memWrite;
		memReq.wdata = sysBus;
		case (ctrl.addrSel)
			cpuTypes::addrAluOut: memReq.addr = aluOut;
			cpuTypes::addrSp:     memReq.addr = sp;
			default:              memReq.addr = pc;
		endcase
	end

	regBlock regs (
		.Clock (Clock),
		.rstN  (rstN),
		.rs1   (ir[8:6]),
		.rs2   (rs2Idx),
		.rw    (ir[11:9]),
		.we    (ctrl.regWe),
		.wData (regWData),
		.rd1   (rd1),
		.rd2   (rd2)
	);

	alu aluUnit (
		.a      (op1),
		.b      (op2),
		.op     (ctrl.aluOp),
		.result (aluResult),
		.flags  (aluFlags)
	);

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			pc <= resetPc;
			sp <= stackTop;
			ir <= '0;
			flags <= '0;
			instrArriving <= 1'b0;
		end else begin
			if (ctrl.pcWe)
				pc <= pcIn;
			if (ctrl.spWe)
				sp <= aluOut;  // pre-computed SP plus or minus one
			if (ctrl.irWe)
				ir <= sysBus;
			if (ctrl.flagWe)
				flags <= aluFlags;
			instrArriving <= ctrl.memRead && (ctrl.addrSel == cpuTypes::addrPc);
		end
	end

	always_ff @(posedge Clock) begin
		if (ctrl.lrWe)
			lr <= pc;  // already points past the JAL
		if (ctrl.aluWe)
			aluOut <= aluResult;
	end

endmodule

/* logic/control.sv */
module control (
	input  logic              Clock,
	input  logic              rstN,
	input  cpuTypes::opcode_t opcode,
	input  cpuTypes::flags_t  flags,
	output cpuTypes::ctrl_t   ctrl,
	output logic              halted
);

	cpuTypes::cpuState_t state, nextState;

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN)
			state <= cpuTypes::sIdle;
		else
			state <= nextState;
	end

	assign halted = (state == cpuTypes::sHalted);

	always_comb begin
		ctrl = '0;  // all selects default to their first entry
		nextState = cpuTypes::sFetch;
		case (state)
			cpuTypes::sIdle: nextState = cpuTypes::sFetch;

			cpuTypes::sFetch: begin
				ctrl.memRead = 1'b1;
				ctrl.addrSel = cpuTypes::addrPc;
				nextState = cpuTypes::sDecode;
			end

			cpuTypes::sDecode: begin
				ctrl.busSel = cpuTypes::busMem;
				ctrl.irWe = 1'b1;
				ctrl.pcSel = cpuTypes::pcPlus1;
				ctrl.pcWe = 1'b1;
				case (opcode)
					cpuTypes::opLd, cpuTypes::opPop: nextState = cpuTypes::sMemAddr;
					cpuTypes::opHalt:                nextState = cpuTypes::sHalted;
					default:                         nextState = cpuTypes::sExecute;
				endcase
			end

			cpuTypes::sExecute: begin
				nextState = cpuTypes::sFetch;
				case (opcode)
					cpuTypes::opAdd, cpuTypes::opSub, cpuTypes::opAnd, cpuTypes::opOr,
					cpuTypes::opXor, cpuTypes::opShl, cpuTypes::opShr: begin
						ctrl.aluOp = cpuTypes::aluOp_t'(opcode[2:0]);
						ctrl.aluWe = 1'b1;
						ctrl.flagWe = 1'b1;
						nextState = cpuTypes::sWriteBack;
					end
					cpuTypes::opAddi: begin
						ctrl.op2Sel = cpuTypes::op2Imm;
						ctrl.aluWe = 1'b1;
						ctrl.flagWe = 1'b1;
						nextState = cpuTypes::sWriteBack;
					end
					cpuTypes::opSt: begin
						ctrl.op2Sel = cpuTypes::op2Imm;  // rs1 + imm6
						ctrl.aluWe = 1'b1;
						nextState = cpuTypes::sMemAddr;
					end
					cpuTypes::opPush: begin
						ctrl.op1Sel = cpuTypes::op1Sp;
						ctrl.op2Sel = cpuTypes::op2One;
						ctrl.aluOp = cpuTypes::aluSub;  // predecrement
						ctrl.aluWe = 1'b1;
						nextState = cpuTypes::sMemAddr;
					end
					cpuTypes::opBz, cpuTypes::opJal: begin
						ctrl.op1Sel = cpuTypes::op1Pc;
						ctrl.op2Sel = cpuTypes::op2Imm;
						ctrl.immSel = 1'b1;
						ctrl.pcSel = cpuTypes::pcAluOut;
						ctrl.lrWe = (opcode == cpuTypes::opJal);
						// the only place the zero flag steers anything
						ctrl.pcWe = (opcode == cpuTypes::opJal) || flags[cpuTypes::flagZero];
					end
					cpuTypes::opRet: begin
						ctrl.pcSel = cpuTypes::pcLr;
						ctrl.pcWe = 1'b1;
					end
					default: nextState = cpuTypes::sFetch;
				endcase
			end

			cpuTypes::sMemAddr: begin
				nextState = cpuTypes::sFetch;
				case (opcode)
					cpuTypes::opLd: begin
						ctrl.op2Sel = cpuTypes::op2Imm;
						ctrl.aluWe = 1'b1;
						nextState = cpuTypes::sMemRead;
					end
					cpuTypes::opPop: begin
						ctrl.op1Sel = cpuTypes::op1Sp;  // SP + 1 ready for writeBack
						ctrl.op2Sel = cpuTypes::op2One;
						ctrl.aluWe = 1'b1;
						nextState = cpuTypes::sMemRead;
					end
					cpuTypes::opSt, cpuTypes::opPush: begin
						ctrl.memWrite = 1'b1;
						ctrl.addrSel = cpuTypes::addrAluOut;
						ctrl.busSel = cpuTypes::busRd2;
						ctrl.rdAsRs2 = 1'b1;
						if (opcode == cpuTypes::opPush)
							nextState = cpuTypes::sWriteBack;
					end
					default: nextState = cpuTypes::sFetch;
				endcase
			end

			cpuTypes::sMemRead: begin
				ctrl.memRead = 1'b1;
				ctrl.addrSel = (opcode == cpuTypes::opPop) ? cpuTypes::addrSp
				                                           : cpuTypes::addrAluOut;
				nextState = cpuTypes::sWriteBack;
			end

			cpuTypes::sWriteBack: begin
				case (opcode)
					cpuTypes::opLd, cpuTypes::opPop: begin
						ctrl.busSel = cpuTypes::busMem;  // read data arrives now
						ctrl.wdSel = 1'b1;
						ctrl.regWe = 1'b1;
						ctrl.spWe = (opcode == cpuTypes::opPop);
					end
					cpuTypes::opPush: ctrl.spWe = 1'b1;
					default:          ctrl.regWe = 1'b1;  // rd from aluOut
				endcase
			end

			cpuTypes::sHalted: nextState = cpuTypes::sHalted;  // until reset

			default: nextState = cpuTypes::sIdle;
		endcase
	end

endmodule

/* logic/cpu.sv */
module cpu #(
	parameter cpuTypes::word_t resetPc  = 16'h0000,
	parameter cpuTypes::word_t stackTop = 16'h00FF
) (
	input  logic              Clock,
	input  logic              rstN,
	input  cpuTypes::word_t   memRData,
	output cpuTypes::memReq_t memReq,
	output logic              halted
);

	cpuTypes::ctrl_t   ctrl;
	cpuTypes::opcode_t opcode;
	cpuTypes::flags_t  flags;  // as latched at the last ALU execute

	control ctrlUnit (
		.Clock  (Clock),
		.rstN   (rstN),
		.opcode (opcode),
		.flags  (flags),
		.ctrl   (ctrl),
		.halted (halted)
	);

	datapath #(
		.resetPc  (resetPc),
		.stackTop (stackTop)
	) dp (
		.Clock    (Clock),
		.rstN     (rstN),
		.ctrl     (ctrl),
		.memRData (memRData),
		.memReq   (memReq),
		.opcode   (opcode),
		.flags    (flags)
	);

endmodule

/* tests/cpu_checker.sv */
module cpuChecker #(
	parameter cpuTypes::word_t resetPc  = 16'h0000,
	parameter cpuTypes::word_t stackTop = 16'h00FF
) (
	input logic              Clock,
	input logic              rstN,
	input cpuTypes::memReq_t memReq,
	input cpuTypes::opcode_t opcode,
	input logic              halted
);
	timeunit 1ns;
	timeprecision 1ps;

	int   failCount = 0;
	logic seenRequest;  // any request since reset release
	logic pushSeen;

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			seenRequest <= 1'b0;
			pushSeen <= 1'b0;
		end else begin
			if (memReq.read || memReq.write)
				seenRequest <= 1'b1;
			if (memReq.write && (opcode == cpuTypes::opPush))
				pushSeen <= 1'b1;
		end
	end

	quietInReset: assert property (@(posedge Clock)
		!rstN |-> !memReq.read && !memReq.write && !halted)
		else begin
			failCount++;
			$error("memory request or halted active while reset is asserted");
		end

	// first request out of reset is the instruction fetch at resetPc
	firstFetch: assert property (@(posedge Clock) disable iff (!rstN)
		!seenRequest && (memReq.read || memReq.write)
		|-> memReq.read && (memReq.addr == resetPc))
		else begin
			failCount++;
			$error("first request after reset is not a read of the reset PC");
		end

	readWriteExclusive: assert property (@(posedge Clock) disable iff (!rstN)
		!(memReq.read && memReq.write))
		else begin
			failCount++;
			$error("read and write requested in the same cycle");
		end

	firstPush: assert property (@(posedge Clock) disable iff (!rstN)
		memReq.write && (opcode == cpuTypes::opPush) && !pushSeen
		|-> memReq.addr == stackTop - 16'd1)
		else begin
			failCount++;
			$error("first push wrote %h instead of the slot below the stack top",
				$sampled(memReq.addr));
		end

	idleWhenHalted: assert property (@(posedge Clock) disable iff (!rstN)
		halted |-> !memReq.read && !memReq.write)
		else begin
			failCount++;
			$error("memory request issued after the core halted");
		end

endmodule

bind cpu cpuChecker #(
	.resetPc  (resetPc),
	.stackTop (stackTop)
) chk (
	.Clock  (Clock),
	.rstN   (rstN),
	.memReq (memReq),
	.opcode (opcode),
	.halted (halted)
);

/* tests/cpuTb.sv */
module cpuTb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam cpuTypes::word_t resetPc  = 16'h0000;
	localparam cpuTypes::word_t stackTop = 16'h00FF;
	localparam cpuTypes::word_t dataA    = 16'h1234;  // preset at 0x40
	localparam cpuTypes::word_t dataB    = 16'h0F0F;  // preset at 0x41
	localparam cpuTypes::word_t immA     = 16'd5;
	localparam cpuTypes::word_t immB     = 16'd3;
	localparam cpuTypes::word_t negImm   = 16'hFFF9;  // imm6 of -7, sign extended

	logic              Clock;
	logic              rstN;
	cpuTypes::word_t   memRData;
	cpuTypes::memReq_t memReq;
	logic              halted;

	cpuTypes::word_t   mem [256];
	cpuTypes::word_t   expected [256];
	logic              expectValid [256];
	logic              written [256];
	cpuTypes::memReq_t pending;  // request captured mid-cycle
	int                loadAddr;
	int                errorCount;
	int                checkerFails;

	cpu #(
		.resetPc  (resetPc),
		.stackTop (stackTop)
	) DUT (
		.Clock    (Clock),
		.rstN     (rstN),
		.memRData (memRData),
		.memReq   (memReq),
		.halted   (halted)
	);

	always #50 Clock = ~Clock;

	// memory model with one cycle read latency and immediate writes
	always @(negedge Clock) begin
		pending = memReq;
	end

	always @(posedge Clock) begin
		#5;
		if (pending.read)
			memRData = mem[pending.addr[7:0]];
		if (pending.write) begin
			mem[pending.addr[7:0]] = pending.wdata;
			written[pending.addr[7:0]] = 1'b1;
		end
	end

	storeAddress: assert property (@(posedge Clock) disable iff (!rstN)
		memReq.write |-> (memReq.addr[15:8] == 8'h00) && expectValid[memReq.addr[7:0]])
		else begin
			errorCount++;
			$display("unexpected write to address %h", $sampled(memReq.addr));
		end

	storeValue: assert property (@(posedge Clock) disable iff (!rstN)
		memReq.write && (memReq.addr[15:8] == 8'h00) && expectValid[memReq.addr[7:0]]
		|-> memReq.wdata == expected[memReq.addr[7:0]])
		else begin
			errorCount++;
			$display("** Error: memReq.wdata at address %h: expected %h, got %h",
				$sampled(memReq.addr), expected[$sampled(memReq.addr[7:0])],
				$sampled(memReq.wdata));
		end

	function automatic cpuTypes::word_t regOp(cpuTypes::opcode_t op, int rd, int rs1, int rs2);
		return {op, rd[2:0], rs1[2:0], rs2[2:0], 3'b000};
	endfunction

	function automatic cpuTypes::word_t immOp(cpuTypes::opcode_t op, int rd, int rs1, int imm);
		return {op, rd[2:0], rs1[2:0], imm[5:0]};
	endfunction

	function automatic cpuTypes::word_t jumpOp(cpuTypes::opcode_t op, int imm);
		return {op, 3'b000, imm[8:0]};
	endfunction

	task automatic placeInstr(input cpuTypes::word_t instr);
		mem[loadAddr] = instr;
		loadAddr++;
	endtask

	task automatic expectStore(input int addr, input cpuTypes::word_t value);
		expected[addr] = value;
		expectValid[addr] = 1'b1;
	endtask

	task automatic loadProgram();
		for (int i = 0; i < 256; i++) begin
			mem[i] = {8'hF0, i[7:0]};  // stray fetches decode as HALT
			expectValid[i] = 1'b0;
			written[i] = 1'b0;
			expected[i] = '0;
		end
		mem[8'h40] = dataA;
		mem[8'h41] = dataB;
		loadAddr = 0;
		placeInstr(immOp(cpuTypes::opAddi, 1, 0, 5));
		placeInstr(immOp(cpuTypes::opAddi, 2, 0, 3));
		placeInstr(immOp(cpuTypes::opAddi, 3, 0, -7));
		placeInstr(immOp(cpuTypes::opAddi, 7, 0, 16));
		placeInstr(regOp(cpuTypes::opShl, 7, 7, 0));
		placeInstr(regOp(cpuTypes::opShl, 7, 7, 0));
		placeInstr(regOp(cpuTypes::opShl, 7, 7, 0));  // r7 = 0x80 store base
		placeInstr(regOp(cpuTypes::opShr, 6, 7, 0));  // r6 = 0x40 data base
		placeInstr(regOp(cpuTypes::opAdd, 4, 1, 2));
		placeInstr(immOp(cpuTypes::opSt, 4, 7, 0));
		placeInstr(regOp(cpuTypes::opSub, 4, 1, 2));
		placeInstr(immOp(cpuTypes::opSt, 4, 7, 1));
		placeInstr(regOp(cpuTypes::opAnd, 4, 1, 3));
		placeInstr(immOp(cpuTypes::opSt, 4, 7, 2));
		placeInstr(regOp(cpuTypes::opOr, 4, 1, 3));
		placeInstr(immOp(cpuTypes::opSt, 4, 7, 3));
		placeInstr(regOp(cpuTypes::opXor, 4, 1, 3));
		placeInstr(immOp(cpuTypes::opSt, 4, 7, 4));
		placeInstr(regOp(cpuTypes::opShl, 4, 3, 0));
		placeInstr(immOp(cpuTypes::opSt, 4, 7, 5));
		placeInstr(regOp(cpuTypes::opShr, 4, 3, 0));
		placeInstr(immOp(cpuTypes::opSt, 4, 7, 6));
		placeInstr(immOp(cpuTypes::opSt, 3, 7, 7));
		placeInstr(immOp(cpuTypes::opSt, 6, 7, 8));
		placeInstr(immOp(cpuTypes::opLd, 1, 6, 0));  // load, modify, store back
		placeInstr(immOp(cpuTypes::opLd, 2, 6, 1));
		placeInstr(regOp(cpuTypes::opAdd, 4, 1, 2));
		placeInstr(immOp(cpuTypes::opSt, 4, 7, 9));
		placeInstr(immOp(cpuTypes::opAddi, 1, 1, -1));
		placeInstr(immOp(cpuTypes::opSt, 1, 6, 2));
		placeInstr(immOp(cpuTypes::opLd, 5, 6, 2));
		placeInstr(regOp(cpuTypes::opXor, 5, 5, 2));
		placeInstr(immOp(cpuTypes::opSt, 5, 7, 10));
		placeInstr(regOp(cpuTypes::opSub, 4, 2, 2));  // zero result
		placeInstr(jumpOp(cpuTypes::opBz, 1));        // taken, skips next
		placeInstr(immOp(cpuTypes::opSt, 2, 7, 11));
		placeInstr(immOp(cpuTypes::opSt, 1, 7, 12));
		placeInstr(regOp(cpuTypes::opAdd, 4, 1, 2));  // non-zero result
		placeInstr(jumpOp(cpuTypes::opBz, 1));        // falls through
		placeInstr(immOp(cpuTypes::opSt, 2, 7, 13));
		placeInstr(immOp(cpuTypes::opAddi, 5, 0, 9));
		placeInstr(jumpOp(cpuTypes::opJal, 6));       // 0x2A + 6 = 0x30
		placeInstr(immOp(cpuTypes::opSt, 5, 7, 14));
		placeInstr(immOp(cpuTypes::opSt, 3, 7, 15));
		placeInstr(jumpOp(cpuTypes::opHalt, 0));
		loadAddr = 'h30;  // subroutine
		placeInstr(immOp(cpuTypes::opPush, 5, 0, 0));
		placeInstr(immOp(cpuTypes::opAddi, 5, 0, 22));
		placeInstr(immOp(cpuTypes::opSt, 5, 7, 16));
		placeInstr(immOp(cpuTypes::opPop, 5, 0, 0));
		placeInstr(immOp(cpuTypes::opAddi, 3, 5, 1));
		placeInstr(jumpOp(cpuTypes::opRet, 0));
	endtask

	task automatic buildExpectations();
		expectStore('h80, immA + immB);
		expectStore('h81, immA - immB);
		expectStore('h82, immA & negImm);
		expectStore('h83, immA | negImm);
		expectStore('h84, immA ^ negImm);
		expectStore('h85, negImm << 1);
		expectStore('h86, negImm >> 1);  // logical shift
		expectStore('h87, negImm);
		expectStore('h88, (16'd16 << 3) >> 1);
		expectStore('h89, dataA + dataB);
		expectStore('h42, dataA - 16'd1);
		expectStore('h8A, (dataA - 16'd1) ^ dataB);
		expectStore('h8C, dataA - 16'd1);  // 0x8B is the wrong path
		expectStore('h8D, dataB);
		expectStore(stackTop - 1, 16'd9);
		expectStore('h90, 16'd22);
		expectStore('h8E, 16'd9);
		expectStore('h8F, 16'd9 + 16'd1);
	endtask

	task automatic waitForHalt();
		int cycles;
		cycles = 0;
		while (!halted && (cycles < 2000)) begin
			@(negedge Clock);
			cycles++;
		end
		if (!halted) begin
			errorCount++;
			$display("timeout: halted did not rise within 2000 cycles");
		end
	endtask

	initial begin
		Clock = 1'b0;
		rstN = 1'b0;
		memRData = '0;
		pending = '0;
		errorCount = 0;
		loadProgram();
		buildExpectations();
		repeat (16) @(posedge Clock);
		#5 rstN = 1'b1;
		waitForHalt();
		repeat (4) @(negedge Clock);  // let the halt checks see a few idle cycles
		for (int i = 0; i < 256; i++) begin
			if (expectValid[i]) begin
				assert (written[i])
				else begin
					errorCount++;
					$display("store to address %h never happened", i[7:0]);
				end
			end
		end
		checkerFails = DUT.chk.failCount;
		$display("closing report: %0d testbench errors, %0d checker errors",
			errorCount, checkerFails);
		if ((errorCount == 0) && (checkerFails == 0))
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

/* sources.f */
logic/cpuTypes.sv
logic/alu.sv
logic/regBlock.sv
logic/datapath.sv
logic/control.sv
logic/cpu.sv
tests/cpu_checker.sv
tests/cpuTb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		--top-module cpuTb -f sources.f -o cpuSim
	./obj_dir/cpuSim +verilator+error+limit+100 | \
		awk '{ print } /SIMULATION PASSED/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
